// File: all.f
+incdir+bench
hdl/xmit_pkg.sv
hdl/frame_assembler.sv
hdl/frame_buffer.sv
hdl/crc16_gen.sv
hdl/medium_timer.sv
hdl/xmit_controller.sv
hdl/xmit_top.sv
bench/tb_xmit_top.sv

// File: bench/xmit_ref.svh
`ifndef XMIT_REF_SVH
`define XMIT_REF_SVH

typedef byte_t byte_q_t[$];

// ccitt crc computed one data bit at a time, msb first
function automatic crc_t ref_crc(byte_q_t bytes);
    crc_t c;
    logic fb;
    c = 16'hffff;
    foreach (bytes[i]) begin
        for (int b = 7; b >= 0; b--) begin
            fb = c[15] ^ bytes[i][b];
            c = {c[14:0], 1'b0};
            if (fb)
                c = c ^ 16'h1021;
        end
    end
    return c;
endfunction

// bytes expected on the modulator side for one copy of a frame
function automatic byte_q_t build_frame(int pre_len, byte_t dest, byte_t src, byte_t ftype,
                                        byte_q_t payload);
    byte_q_t f;
    byte_q_t covered;
    crc_t c;
    for (int i = 0; i < pre_len; i++)
        f.push_back(PREAMBLE_BYTE);
    f.push_back(SFD_BYTE);
    covered.push_back(dest);
    covered.push_back(src);
    covered.push_back(ftype);
    foreach (payload[i])
        covered.push_back(payload[i]);
    foreach (covered[i])
        f.push_back(covered[i]);
    if (ftype != FTYPE_NO_CRC) begin
        c = ref_crc(covered);
        f.push_back(c[15:8]);
        f.push_back(c[7:0]);
    end
    return f;
endfunction

`endif

// File: bench/tb_xmit_top.sv
`default_nettype none

module tb_xmit_top import xmit_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

`include "xmit_ref.svh"

    localparam int    PRE_LEN      = 2;
    localparam int    DIFS_TICKS   = 8;
    localparam int    SLOT_TICKS   = 2;
    localparam int    ACK_TICKS    = 20;
    localparam int    CARRIER_HOLD = 40;
    localparam byte_t MAC_ADDR     = 8'ha7;
    localparam int    NROWS        = 7;

    // name, destination, type, payload length, cardet after byte (-1 none), missing acks
    string row_name   [NROWS] = '{"data_frame", "no_crc", "max_payload", "carrier",
                                  "ack_retry", "ack_give_up", "ack_first"};
    byte_t row_dest   [NROWS] = '{8'h1a, 8'h2b, 8'h3c, 8'h4d, 8'h5e, 8'h6f, 8'h70};
    byte_t row_type   [NROWS] = '{8'h31, 8'h30, 8'h31, 8'h31, 8'h32, 8'h32, 8'h32};
    int    row_len    [NROWS] = '{20, 9, 256, 30, 12, 8, 4};
    int    row_cardet [NROWS] = '{-1, -1, -1, 12, -1, -1, -1};
    int    row_miss   [NROWS] = '{0, 0, 0, 0, 2, 6, 0};

    logic       clk;
    logic       rst;
    logic       xvalid;
    logic       xsend;
    byte_t      xdata;
    logic       xrdy;
    byte_t      mac;
    logic       cardet;
    logic       ack_received;
    logic       tick;
    logic       mx_rdy;
    logic       mx_valid;
    byte_t      mx_data;
    logic       xbusy;
    logic [3:0] xerrcnt;

    byte_q_t    got;
    logic [3:0] exp_err;
    int         cycle_ct = 0;
    int         cycle_limit = 32'h7fffffff;

    xmit_top #(
        .preamble_len(PRE_LEN),
        .difs_ticks(DIFS_TICKS),
        .slot_ticks(SLOT_TICKS),
        .ack_ticks(ACK_TICKS)
    ) xmit_top_inst (
        .clk(clk), .rst(rst),
        .xvalid(xvalid), .xsend(xsend), .xdata(xdata), .xrdy(xrdy), .mac(mac),
        .cardet(cardet), .ack_received(ack_received), .tick(tick),
        .mx_rdy(mx_rdy), .mx_valid(mx_valid), .mx_data(mx_data),
        .xbusy(xbusy), .xerrcnt(xerrcnt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_ct <= cycle_ct + 1;
        if (cycle_ct > cycle_limit) begin
            $display("timeout: frames did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_byte(string name, byte_t expv, byte_t act);
        if (act !== expv)
            stop_on_error($sformatf("Mismatch %s: expected %02h, actual %02h", name, expv, act));
    endtask

    task automatic check_crc(string name, crc_t expv, crc_t act);
        if (act !== expv)
            stop_on_error($sformatf("Mismatch %s: expected %04h, actual %04h", name, expv, act));
    endtask

    task automatic check_errcnt(string name, logic [3:0] expv, logic [3:0] act);
        if (act !== expv)
            stop_on_error($sformatf("Mismatch %s xerrcnt: expected %0d, actual %0d",
                                    name, expv, act));
    endtask

    function automatic int expected_sends(int r);
        if (row_type[r] != FTYPE_ACK_REQ)
            return 1;
        return (row_miss[r] > MAX_ATTEMPTS) ? MAX_ATTEMPTS + 1 : row_miss[r] + 1;
    endfunction

    // generous bound from byte counts, attempts and the longest waits
    function automatic int cycle_budget();
        int total;
        int fl;
        total = 0;
        for (int r = 0; r < NROWS; r++) begin
            fl = PRE_LEN + 6 + row_len[r];
            total += (row_len[r] + 8) * 2;
            total += expected_sends(r) * (fl * 4 + 8 * ACK_TICKS + 20);
            if (row_cardet[r] >= 0)
                total += CARRIER_HOLD + 32 * (DIFS_TICKS + 15 * SLOT_TICKS);
        end
        return 2 * total + 400;
    endfunction

    task automatic compare_copy(string name, byte_q_t expq, byte_q_t act, byte_t ftype);
        int n;
        n = expq.size();
        if (ftype == FTYPE_NO_CRC) begin
            for (int i = 0; i < n; i++)
                check_byte($sformatf("%s byte %0d", name, i), expq[i], act[i]);
        end else begin
            for (int i = 0; i < n - 2; i++)
                check_byte($sformatf("%s byte %0d", name, i), expq[i], act[i]);
            check_crc($sformatf("%s crc", name), {expq[n-2], expq[n-1]}, {act[n-2], act[n-1]});
        end
    endtask

    // host bytes in order, each held until xrdy lets it through
    task automatic load_frame(byte_t dest, byte_t ftype, byte_q_t payload);
        byte_q_t host;
        host.push_back(dest);
        host.push_back(ftype);
        foreach (payload[i])
            host.push_back(payload[i]);
        for (int i = 0; i < host.size(); i++) begin
            @(negedge clk);
            xvalid = 1'b1;
            xdata  = host[i];
            xsend  = (i == host.size() - 1) && (payload.size() < MAX_PAYLOAD);
            #1;
            while (!xrdy) begin
                @(negedge clk);
                #1;
            end
        end
    endtask

    task automatic run_row(int r);
        byte_q_t payload;
        byte_q_t expq;
        int      copies;
        int      hold;
        bit      carrier_done;
        bit      done;
        for (int i = 0; i < row_len[r]; i++)
            payload.push_back(byte_t'($urandom));
        expq = build_frame(PRE_LEN, row_dest[r], MAC_ADDR, row_type[r], payload);
        got.delete();
        ack_received = 1'b0;
        load_frame(row_dest[r], row_type[r], payload);
        copies       = 0;
        hold         = 0;
        carrier_done = 1'b0;
        done         = 1'b0;
        while (!done) begin
            @(negedge clk);
            xvalid       = 1'b0;
            xsend        = 1'b0;
            mx_rdy       = ($urandom % 4) != 0;
            tick         = ($urandom % 3) == 0;
            ack_received = copies > row_miss[r];
            if (hold > 0) begin
                hold--;
                // frame restarts from the first byte once carrier clears
                if (hold == 0) begin
                    cardet = 1'b0;
                    got.delete();
                end
            end else if (!carrier_done && row_cardet[r] >= 0 && got.size() == row_cardet[r]) begin
                cardet       = 1'b1;
                hold         = CARRIER_HOLD;
                carrier_done = 1'b1;
            end
            #1;
            if (mx_valid && mx_rdy)
                got.push_back(mx_data);
            if (got.size() == expq.size()) begin
                compare_copy(row_name[r], expq, got, row_type[r]);
                copies++;
                got.delete();
            end
            done = !xbusy;
        end
        if (copies != expected_sends(r))
            stop_on_error($sformatf("Mismatch %s sends: expected %0d, actual %0d",
                                    row_name[r], expected_sends(r), copies));
        if (got.size() != 0)
            stop_on_error($sformatf("%s left %0d bytes of an unfinished frame on the link",
                                    row_name[r], got.size()));
        if (row_type[r] == FTYPE_ACK_REQ && row_miss[r] > MAX_ATTEMPTS && exp_err != 4'hf)
            exp_err = exp_err + 4'd1;
        check_errcnt(row_name[r], exp_err, xerrcnt);
    endtask

    initial begin
        void'($urandom(32'hbfa4));
        rst          = 1'b1;
        xvalid       = 1'b0;
        xsend        = 1'b0;
        xdata        = '0;
        mac          = MAC_ADDR;
        cardet       = 1'b0;
        ack_received = 1'b0;
        tick         = 1'b0;
        mx_rdy       = 1'b0;
        exp_err      = '0;
        cycle_limit  = cycle_budget();
        repeat (16) @(negedge clk);
        rst = 1'b0;
        check_errcnt("after_reset", exp_err, xerrcnt);
        for (int r = 0; r < NROWS; r++)
            run_row(r);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/crc16_gen.sv
`default_nettype none

module crc16_gen import xmit_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  crc_clr,
    input  logic  crc_en,
    input  logic  crc_xmit,
    input  byte_t rd_data,
    input  logic  mx_rdy,
    input  logic  mx_valid,
    output byte_t mx_data,
    output logic  crc_done
);

    localparam crc_t crc_poly = 16'h1021;
    localparam crc_t crc_init = 16'hffff;

    crc_t crc;
    logic lo_sel;
    logic take;

    // ccitt update, msb first
    function automatic crc_t crc_byte(crc_t c, byte_t d);
        crc_t r;
        r = c ^ {d, 8'h00};
        for (int i = 0; i < 8; i++)
            r = r[15] ? ({r[14:0], 1'b0} ^ crc_poly) : {r[14:0], 1'b0};
        return r;
    endfunction

    assign take     = mx_valid && mx_rdy;
    assign mx_data  = crc_xmit ? (lo_sel ? crc[7:0] : crc[15:8]) : rd_data;
    assign crc_done = crc_xmit && take && lo_sel;

    always_ff @(posedge clk) begin
        if (rst || crc_clr) begin
            crc    <= crc_init;
            lo_sel <= 1'b0;
        end else begin
            if (crc_en && take)
                crc <= crc_byte(crc, rd_data);
            if (crc_xmit && take)
                lo_sel <= !lo_sel;
        end
    end

endmodule

`default_nettype wire

// File: hdl/frame_assembler.sv
`default_nettype none

module frame_assembler import xmit_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  src_sel_t src_sel,
    input  logic     wr_en,
    input  logic     xvalid,
    input  byte_t    xdata,
    input  byte_t    mac,
    output byte_t    wr_data,
    output byte_t    frame_type
);

    // host bytes written since the preamble, saturates at 2
    logic [1:0] host_idx;
    logic       host_wr;

    assign host_wr = wr_en && (src_sel == SRC_HOST) && xvalid;

    always_comb begin
        case (src_sel)
            SRC_PREAMBLE: wr_data = PREAMBLE_BYTE;
            SRC_SFD:      wr_data = SFD_BYTE;
            SRC_MAC:      wr_data = mac;
            default:      wr_data = xdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            host_idx   <= '0;
            frame_type <= '0;
        end else if (wr_en && src_sel == SRC_PREAMBLE) begin
            host_idx <= '0;
        end else if (host_wr) begin
            if (host_idx != 2'd2)
                host_idx <= host_idx + 2'd1;
            // second host byte is the frame type
            if (host_idx == 2'd1)
                frame_type <= xdata;
        end
    end

endmodule

`default_nettype wire

// File: hdl/frame_buffer.sv
`default_nettype none

module frame_buffer import xmit_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      wr_en,
    input  byte_t     wr_data,
    input  logic      rd_en,
    input  logic      buf_restart,
    output byte_t     rd_data,
    output buf_addr_t wr_count,
    output buf_addr_t rd_count
);

    byte_t     mem [2**$bits(buf_addr_t)];
    buf_addr_t wr_ptr;
    buf_addr_t rd_ptr;
    buf_addr_t wr_addr;
    logic      new_frame;

    // a write after a readout starts the next frame at address 0
    assign new_frame = wr_en && (rd_ptr != '0);
    assign wr_addr   = new_frame ? '0 : wr_ptr;
    assign wr_count  = wr_ptr;
    assign rd_count  = rd_ptr;

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        if (rd_en)
            rd_data <= mem[rd_ptr];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_addr + 9'd1;
            if (buf_restart || new_frame)
                rd_ptr <= '0;
            else if (rd_en)
                rd_ptr <= rd_ptr + 9'd1;
        end
    end

    a_wr_no_wrap: assert property (@(posedge clk) disable iff (rst)
        wr_en |=> wr_ptr != '0);

endmodule

`default_nettype wire

// File: hdl/medium_timer.sv
`default_nettype none

module medium_timer import xmit_pkg::*; #(
    parameter int difs_ticks = 16,
    parameter int slot_ticks = 4,
    parameter int ack_ticks  = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        tick,
    input  logic        timer_start,
    input  timer_mode_t timer_mode,
    output logic        timer_expired
);

    logic [15:0] lfsr;
    logic [15:0] count;
    logic [15:0] load_val;
    logic        active;

    always_comb begin
        case (timer_mode)
            TM_ACK:     load_val = 16'(ack_ticks);
            // difs plus 0..15 random slots
            TM_BACKOFF: load_val = 16'(difs_ticks) + 16'(lfsr[3:0]) * 16'(slot_ticks);
            default:    load_val = 16'(difs_ticks);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr          <= 16'hace1;
            count         <= '0;
            active        <= 1'b0;
            timer_expired <= 1'b0;
        end else begin
            // x^16 + x^14 + x^13 + x^11
            lfsr          <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            timer_expired <= 1'b0;
            if (timer_start) begin
                count  <= load_val;
                active <= 1'b1;
            end else if (active && tick) begin
                if (count <= 16'd1) begin
                    active        <= 1'b0;
                    timer_expired <= 1'b1;
                end else begin
                    count <= count - 16'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/xmit_controller.sv
`default_nettype none

module xmit_controller import xmit_pkg::*; #(
    parameter int preamble_len = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        xvalid,
    input  logic        xsend,
    output logic        xrdy,
    output logic        xbusy,
    input  logic        cardet,
    input  logic        ack_received,
    input  logic        mx_rdy,
    output logic        mx_valid,
    output logic [3:0]  xerrcnt,
    output logic        wr_en,
    output src_sel_t    src_sel,
    output logic        buf_restart,
    output logic        rd_en,
    input  buf_addr_t   wr_count,
    input  buf_addr_t   rd_count,
    input  byte_t       frame_type,
    output logic        crc_clr,
    output logic        crc_en,
    output logic        crc_xmit,
    input  logic        crc_done,
    output logic        timer_start,
    output timer_mode_t timer_mode,
    input  logic        timer_expired
);

    typedef enum logic [3:0] {
        LOAD_PRE, LOAD_SFD, IDLE, LOAD_MAC, LOAD_TYPE, LOAD_DATA,
        SEND_FETCH, SEND_DATA, SEND_CRC, WAIT_DIFS, WAIT_BACKOFF, WAIT_ACK
    } state_t;

    // destination is the first byte covered by the crc
    localparam buf_addr_t crc_first = buf_addr_t'(preamble_len + 2);

    state_t     state, next;
    logic [7:0] pre_ct;
    logic [7:0] data_ct;
    logic [2:0] attempt_ct;
    logic       sending;
    logic       frame_end;
    logic       give_up;
    logic       retry;

    assign sending  = (state == SEND_FETCH) || (state == SEND_DATA) || (state == SEND_CRC);
    assign xrdy     = (state == IDLE) || (state == LOAD_TYPE) || (state == LOAD_DATA);
    assign mx_valid = ((state == SEND_DATA) || (state == SEND_CRC)) && !cardet;
    assign crc_xmit = (state == SEND_CRC);
    assign crc_en   = (state == SEND_DATA) && (rd_count >= crc_first);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= LOAD_PRE;
            pre_ct     <= '0;
            data_ct    <= '0;
            attempt_ct <= '0;
            xbusy      <= 1'b0;
            xerrcnt    <= '0;
        end else begin
            state  <= next;
            pre_ct <= (state == LOAD_PRE) ? pre_ct + 8'd1 : 8'd0;
            if (state == IDLE) begin
                data_ct    <= '0;
                attempt_ct <= '0;
            end
            if (state == LOAD_DATA && xvalid)
                data_ct <= data_ct + 8'd1;
            if (retry)
                attempt_ct <= attempt_ct + 3'd1;
            if (state == IDLE && xvalid)
                xbusy <= 1'b1;
            else if (frame_end)
                xbusy <= 1'b0;
            if (give_up && xerrcnt != 4'hf)
                xerrcnt <= xerrcnt + 4'd1;
        end
    end

    always_comb begin
        next        = state;
        wr_en       = 1'b0;
        src_sel     = SRC_HOST;
        rd_en       = 1'b0;
        buf_restart = 1'b0;
        crc_clr     = 1'b0;
        timer_start = 1'b0;
        timer_mode  = TM_DIFS;
        frame_end   = 1'b0;
        give_up     = 1'b0;
        retry       = 1'b0;
        case (state)
            LOAD_PRE: begin
                // fresh crc for the frame about to be built
                crc_clr = 1'b1;
                wr_en   = 1'b1;
                src_sel = SRC_PREAMBLE;
                if (pre_ct == 8'(preamble_len - 1))
                    next = LOAD_SFD;
            end
            LOAD_SFD: begin
                wr_en   = 1'b1;
                src_sel = SRC_SFD;
                next    = IDLE;
            end
            IDLE: begin
                // destination byte from the host
                if (xvalid) begin
                    wr_en = 1'b1;
                    next  = LOAD_MAC;
                end
            end
            LOAD_MAC: begin
                wr_en   = 1'b1;
                src_sel = SRC_MAC;
                next    = LOAD_TYPE;
            end
            LOAD_TYPE: begin
                if (xvalid) begin
                    wr_en = 1'b1;
                    next  = LOAD_DATA;
                end
            end
            LOAD_DATA: begin
                if (xvalid) begin
                    wr_en = 1'b1;
                    if (xsend || data_ct == 8'(MAX_PAYLOAD - 1))
                        next = SEND_FETCH;
                end
            end
            SEND_FETCH: begin
                rd_en = 1'b1;
                next  = SEND_DATA;
            end
            SEND_DATA: begin
                if (mx_rdy) begin
                    if (rd_count == wr_count) begin
                        if (frame_type == FTYPE_NO_CRC) begin
                            frame_end = 1'b1;
                            next      = LOAD_PRE;
                        end else begin
                            next = SEND_CRC;
                        end
                    end else begin
                        rd_en = 1'b1;
                    end
                end
            end
            SEND_CRC: begin
                if (crc_done) begin
                    if (frame_type == FTYPE_ACK_REQ) begin
                        timer_start = 1'b1;
                        timer_mode  = TM_ACK;
                        next        = WAIT_ACK;
                    end else begin
                        frame_end = 1'b1;
                        next      = LOAD_PRE;
                    end
                end
            end
            WAIT_DIFS, WAIT_BACKOFF: begin
                if (timer_expired) begin
                    if (cardet) begin
                        timer_start = 1'b1;
                        timer_mode  = TM_BACKOFF;
                        next        = WAIT_BACKOFF;
                    end else begin
                        next = SEND_FETCH;
                    end
                end
            end
            WAIT_ACK: begin
                if (ack_received) begin
                    frame_end = 1'b1;
                    next      = LOAD_PRE;
                end else if (timer_expired) begin
                    if (attempt_ct < 3'(MAX_ATTEMPTS)) begin
                        retry       = 1'b1;
                        buf_restart = 1'b1;
                        crc_clr     = 1'b1;
                        next        = SEND_FETCH;
                    end else begin
                        give_up   = 1'b1;
                        frame_end = 1'b1;
                        next      = LOAD_PRE;
                    end
                end
            end
            default: next = LOAD_PRE;
        endcase
        // carrier on the medium: abandon and rewind to the first byte
        if (sending && cardet) begin
            next        = WAIT_DIFS;
            rd_en       = 1'b0;
            buf_restart = 1'b1;
            crc_clr     = 1'b1;
            timer_start = 1'b1;
            timer_mode  = TM_DIFS;
            frame_end   = 1'b0;
        end
    end

    a_no_valid_while_ready: assert property (@(posedge clk) disable iff (rst)
        !(mx_valid && xrdy));

    // buffer contents stay fixed while a frame is on the air
    a_no_write_while_sending: assert property (@(posedge clk) disable iff (rst)
        mx_valid |-> !wr_en);

endmodule

`default_nettype wire

// File: hdl/xmit_pkg.sv
`default_nettype none

package xmit_pkg;

    // one byte on the host, buffer and modulator paths
    typedef logic [7:0] byte_t;

    // frame buffer address, up to 512 bytes
    typedef logic [8:0] buf_addr_t;

    // running frame check sequence
    typedef logic [15:0] crc_t;

    // byte source for a buffer write
    typedef enum logic [1:0] {
        SRC_PREAMBLE,
        SRC_SFD,
        SRC_HOST,
        SRC_MAC
    } src_sel_t;

    // which wait the medium timer is running
    typedef enum logic [1:0] {
        TM_DIFS,
        TM_BACKOFF,
        TM_ACK
    } timer_mode_t;

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hd0;
    // frame types with special handling
    localparam byte_t FTYPE_NO_CRC  = 8'h30;
    localparam byte_t FTYPE_ACK_REQ = 8'h32;

    localparam int MAX_PAYLOAD  = 256;
    localparam int MAX_ATTEMPTS = 5;

endpackage

`default_nettype wire

// File: hdl/xmit_top.sv
`default_nettype none

module xmit_top import xmit_pkg::*; #(
    parameter int preamble_len = 2,
    parameter int difs_ticks   = 16,
    parameter int slot_ticks   = 4,
    parameter int ack_ticks    = 64
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       xvalid,
    input  logic       xsend,
    input  byte_t      xdata,
    output logic       xrdy,
    input  byte_t      mac,
    input  logic       cardet,
    input  logic       ack_received,
    input  logic       tick,
    input  logic       mx_rdy,
    output logic       mx_valid,
    output byte_t      mx_data,
    output logic       xbusy,
    output logic [3:0] xerrcnt
);

    logic        wr_en;
    src_sel_t    src_sel;
    logic        buf_restart;
    logic        rd_en;
    buf_addr_t   wr_count;
    buf_addr_t   rd_count;
    byte_t       wr_data;
    byte_t       rd_data;
    byte_t       frame_type;
    logic        crc_clr;
    logic        crc_en;
    logic        crc_xmit;
    logic        crc_done;
    logic        timer_start;
    timer_mode_t timer_mode;
    logic        timer_expired;

    xmit_controller #(
        .preamble_len(preamble_len)
    ) xmit_controller_inst (
        .clk(clk), .rst(rst),
        .xvalid(xvalid), .xsend(xsend), .xrdy(xrdy), .xbusy(xbusy),
        .cardet(cardet), .ack_received(ack_received),
        .mx_rdy(mx_rdy), .mx_valid(mx_valid), .xerrcnt(xerrcnt),
        .wr_en(wr_en), .src_sel(src_sel), .buf_restart(buf_restart), .rd_en(rd_en),
        .wr_count(wr_count), .rd_count(rd_count), .frame_type(frame_type),
        .crc_clr(crc_clr), .crc_en(crc_en), .crc_xmit(crc_xmit), .crc_done(crc_done),
        .timer_start(timer_start), .timer_mode(timer_mode), .timer_expired(timer_expired)
    );

    frame_assembler frame_assembler_inst (
        .clk(clk), .rst(rst),
        .src_sel(src_sel), .wr_en(wr_en), .xvalid(xvalid), .xdata(xdata), .mac(mac),
        .wr_data(wr_data), .frame_type(frame_type)
    );

    frame_buffer frame_buffer_inst (
        .clk(clk), .rst(rst),
        .wr_en(wr_en), .wr_data(wr_data), .rd_en(rd_en), .buf_restart(buf_restart),
        .rd_data(rd_data), .wr_count(wr_count), .rd_count(rd_count)
    );

    crc16_gen crc16_gen_inst (
        .clk(clk), .rst(rst),
        .crc_clr(crc_clr), .crc_en(crc_en), .crc_xmit(crc_xmit), .rd_data(rd_data),
        .mx_rdy(mx_rdy), .mx_valid(mx_valid), .mx_data(mx_data), .crc_done(crc_done)
    );

    medium_timer #(
        .difs_ticks(difs_ticks),
        .slot_ticks(slot_ticks),
        .ack_ticks(ack_ticks)
    ) medium_timer_inst (
        .clk(clk), .rst(rst),
        .tick(tick), .timer_start(timer_start), .timer_mode(timer_mode),
        .timer_expired(timer_expired)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the transmit controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_xmit_top -f all.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_xmit_top > sim.log 2>&1
status=$?
cat sim.log

if grep -q '^\*\* FAIL \*\*$' sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
